// ==== filelist.f ====
+incdir+design
design/board_pkg.sv
design/i2s_timing_ctrl.sv
design/i2s_mic_receiver.sv
design/i2s_dac_transmitter.sv
design/audio_level_path.sv
design/board_audio_top.sv
verification/i2s_timing_chk.sv
verification/board_audio_tb.sv

// ==== verification/board_audio_tb.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module board_audio_tb;

    localparam int N_FRAMES = 45;                 // DAC frames checked, reset frame too
    localparam int HALF     = `FRAME_BITS / 2;    // Slots per channel
    localparam int TIMEOUT  = N_FRAMES * `FRAME_BITS * 2 * `BCLK_HALF + 500;

    typedef struct packed {
        board_pkg::dac_sample_t sound;
        board_pkg::bar_t        bar;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic [1:0]             key;                  // Active low
    board_pkg::vol_t        sw;
    board_pkg::bar_t        led;
    logic                   mic_sck;
    logic                   mic_ws;
    logic                   mic_lr;
    logic                   mic_sd;
    logic                   aud_mclk;
    logic                   aud_bclk;
    logic                   aud_lrclk;
    logic                   aud_sdata;

    int                     seed = 32'h2de5_790a;
    int                     rnd;
    int                     cycles = 0;
    int                     sound_errors = 0;
    int                     led_errors = 0;
    int                     pin_errors = 0;
    int                     chk_errors = 0;
    int                     mic_idx = 0;          // Bit index seen by the mic
    int                     mic_frame = 0;
    int                     dac_pos = -1;         // Bit index seen by the DAC
    logic                   mic_bclk_q = 1'b0;
    logic                   mic_ws_q = 1'b0;
    logic                   dac_bclk_q = 1'b0;
    logic                   dac_ws_last = 1'b0;   // ws at the previous bclk rise
    logic                   mclk_ref = 1'b0;      // Expected master clock level
    board_pkg::mic_sample_t mic_word;
    board_pkg::mic_sample_t stim_mic [0:63];
    board_pkg::vol_t        stim_sw  [0:63];
    logic [1:0]             stim_key [0:63];
    board_pkg::dac_sample_t cap_left;
    board_pkg::dac_sample_t cap_right;
    board_pkg::bar_t        cap_led;
    board_pkg::dac_sample_t left_q  [$];
    board_pkg::dac_sample_t right_q [$];
    board_pkg::bar_t        led_q   [$];

    board_audio_top dut_i
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .led       ( led       ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .mic_sd    ( mic_sd    ),
        .aud_mclk  ( aud_mclk  ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                    // 4 ns period
    end

    initial
    begin
        rst    <= 1'b1;
        key    = 2'b11;                           // Both keys up
        sw     = '0;
        mic_sd = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    // ------------------------------------------------------------------------
    // Reference model

    function automatic expect_t expected_output(board_pkg::mic_sample_t smp,
                                                board_pkg::vol_t vol, logic [1:0] keys);
        expect_t            e;
        logic signed [31:0] wide;
        int                 mag;
        int                 i;
        wide    = $signed(smp[`MIC_BITS - 1 -: `DAC_BITS]);
        wide    = wide >>> vol;                   // Volume as arithmetic shift
        e.sound = keys[0] ? wide[`DAC_BITS - 1:0] : '0;   // key[0] down mutes
        mag     = $signed(smp[`MIC_BITS - 1 -: 8]);
        mag     = (mag < 0) ? -mag : mag;
        if (mag > 127)
            mag = 127;                            // -128 reads as full scale
        for (i = 0; i < `N_LED; i++)
            e.bar[i] = (i < mag / 16);            // Thermometer from bit 0
        return e;
    endfunction

    task automatic check_sound(string name, board_pkg::dac_sample_t exp_v,
                               board_pkg::dac_sample_t act_v);
        if (act_v !== exp_v)
        begin
            sound_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_led(string name, board_pkg::bar_t exp_v, board_pkg::bar_t act_v);
        if (act_v !== exp_v)
        begin
            led_errors++;
            $display("MISMATCH %s led: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic check_pin(string name, logic exp_v, logic act_v);
        if (act_v !== exp_v)
        begin
            pin_errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    // ------------------------------------------------------------------------
    // Microphone model, acts one clk after each bclk fall

    task automatic pick_stimulus();
        board_pkg::mic_sample_t smp;
        board_pkg::vol_t        vol;
        logic                   mute;
        logic                   freeze;
        rnd    = $random(seed);
        smp    = rnd[`MIC_BITS - 1:0];
        vol    = '0;
        if (mic_frame >= 11 && mic_frame <= 31)
            vol = board_pkg::vol_t'(1 + (mic_frame - 11) / 3);   // 3 frames per step
        mute   = (mic_frame >= 32 && mic_frame <= 34);
        freeze = (mic_frame >= 40 && mic_frame <= 42);
        if (mic_frame == 37)
            smp = '0;                             // Silence, no LEDs
        else if (mic_frame == 38)
            smp = 24'h7f_ffff;                    // Positive full scale
        else if (mic_frame == 39)
            smp = 24'h80_0000;                    // Negative full scale, held by freeze
        mic_word = smp;
        if (mic_frame < 64)
        begin
            stim_mic[mic_frame] = smp;
            stim_sw[mic_frame]  = vol;
            stim_key[mic_frame] = {~freeze, ~mute};
        end
        sw  <= vol;
        key <= {~freeze, ~mute};
        mic_frame++;
    endtask

    always @(posedge clk)
    begin
        if (!rst && mic_bclk_q && !mic_sck)
        begin
            mic_idx = (mic_ws_q && !mic_ws) ? 0 : mic_idx + 1;       // Resync on ws fall
            if (mic_idx == 1)
                pick_stimulus();
            rnd = $random(seed);
            if (mic_idx >= 1 && mic_idx <= `MIC_BITS)
                mic_sd <= mic_word[`MIC_BITS - mic_idx];             // MSB first
            else
                mic_sd <= (mic_idx >= HALF) & rnd[0];                // Junk on the right
        end
        mic_bclk_q <= mic_sck;
        mic_ws_q   <= mic_ws;
    end

    // ------------------------------------------------------------------------
    // DAC capture on bclk rises

    always @(posedge clk)
    begin
        if (!rst && !dac_bclk_q && aud_bclk)
        begin
            dac_pos     = (dac_ws_last && !aud_lrclk) ? 0 : dac_pos + 1;
            dac_ws_last = aud_lrclk;
            if (dac_pos == 0)
                cap_led = led;                    // Level left by the last frame
            if (dac_pos % HALF >= 1 && dac_pos % HALF <= `DAC_BITS)
            begin
                if (dac_pos < HALF)
                    cap_left[`DAC_BITS - dac_pos] = aud_sdata;
                else
                    cap_right[`DAC_BITS - dac_pos + HALF] = aud_sdata;
            end
            else
                check_pin($sformatf("idle slot %0d", dac_pos), 1'b0, aud_sdata);
            if (dac_pos == HALF + `DAC_BITS)      // Right LSB done
            begin
                left_q.push_back(cap_left);
                right_q.push_back(cap_right);
                led_q.push_back(cap_led);
            end
        end
        dac_bclk_q <= aud_bclk;
    end

    // ------------------------------------------------------------------------
    // Fixed and divided pins

    always @(posedge clk)
    begin
        check_pin("mic_lr", 1'b0, mic_lr);        // Left channel select
        check_pin("aud_mclk", mclk_ref, aud_mclk);
        mclk_ref = rst ? 1'b0 : ~mclk_ref;        // clk/2 once out of reset
    end

    // ------------------------------------------------------------------------
    // Compare, frame k stimulus against frame k+1 capture

    initial
    begin
        expect_t                e;
        board_pkg::dac_sample_t exp_sound;
        board_pkg::bar_t        exp_led;
        string                  name;
        int                     f;
        int                     j;
        exp_led = '0;
        for (j = 0; j < N_FRAMES; j++)
        begin
            while (left_q.size() == 0)
                @(posedge clk);
            f         = j - 1;                    // Stimulus heard in this frame
            exp_sound = '0;
            if (f >= 0)
            begin
                e         = expected_output(stim_mic[f], stim_sw[f], stim_key[f]);
                exp_sound = e.sound;
                if (stim_key[f][1])
                    exp_led = e.bar;              // Held while key[1] is down
            end
            name = (f < 0)   ? "reset" : (f <= 10) ? "plain" : (f <= 31) ? "volume" :
                   (f <= 36) ? "mute"  : (f <= 39) ? "level" : "freeze";
            check_sound($sformatf("%s frame %0d left", name, j), exp_sound, left_q.pop_front());
            check_sound($sformatf("%s frame %0d right", name, j), exp_sound, right_q.pop_front());
            check_led($sformatf("%s frame %0d", name, j), exp_led, led_q.pop_front());
        end
        chk_errors = dut_i.timing_i.timing_chk_i.fail_count;
        $display("errors: sound %0d, led %0d, pins %0d, timing %0d",
                 sound_errors, led_errors, pin_errors, chk_errors);
        if (sound_errors + led_errors + pin_errors + chk_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT)
        begin
            $display("timeout: DAC frames stopped arriving");
            $display("Something failed");
            $finish;
        end
    end

endmodule

// ==== verification/i2s_timing_chk.sv ====
`timescale 1ns/1ps

module i2s_timing_chk
(
    input logic clk,
    input logic rst,
    input logic bclk,
    input logic ws,
    input logic mclk,
    input logic sample_bit,
    input logic shift_bit,
    input logic frame_start
);

    int fail_count = 0;                      // Failures seen so far

    ws_on_fall: assert property (@(posedge clk) disable iff (rst) $changed(ws) |-> $fell(bclk))
    else
    begin
        fail_count++;
        $error("ws changed away from a bclk fall");
    end

    sample_once: assert property (@(posedge clk) disable iff (rst) sample_bit |=> !sample_bit)
    else
    begin
        fail_count++;
        $error("sample_bit held for more than one cycle");
    end

    // shift_bit and frame_start share the bclk fall
    shift_once: assert property (@(posedge clk) disable iff (rst)
        (shift_bit || frame_start) |=> !(shift_bit || frame_start))
    else
    begin
        fail_count++;
        $error("shift_bit or frame_start held for more than one cycle");
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !(bclk || ws || mclk || sample_bit || shift_bit || frame_start))
    else
    begin
        fail_count++;
        $error("timing output high during reset");
    end

endmodule

bind i2s_timing_ctrl i2s_timing_chk timing_chk_i
(
    .clk(clk), .rst(rst), .bclk(bclk), .ws(ws), .mclk(mclk),
    .sample_bit(sample_bit), .shift_bit(shift_bit), .frame_start(frame_start)
);

// ==== design/board_audio_top.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module board_audio_top
(
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         key,
    input  logic [`N_VOL - 1:0] sw,
    output logic [`N_LED - 1:0] led,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,
    input  logic               mic_sd,
    output logic               aud_mclk,
    output logic               aud_bclk,
    output logic               aud_lrclk,
    output logic               aud_sdata
);

    logic                             bclk;
    logic                             ws;
    logic                             sample_bit;
    logic                             shift_bit;
    logic                             frame_start;
    logic [$clog2(`FRAME_BITS) - 1:0] bit_index;
    logic                             mic_valid;
    board_pkg::mic_sample_t           mic_sample;
    board_pkg::dac_sample_t           sound;

    // ------------------------------------------------------------------------
    // Shared serial clocks on both GPIO headers

    assign mic_sck   = bclk;
    assign aud_bclk  = bclk;
    assign mic_ws    = ws;
    assign aud_lrclk = ws;
    assign mic_lr    = 1'b0;              // Left channel select

    i2s_timing_ctrl timing_i
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .bclk        ( bclk        ),
        .ws          ( ws          ),
        .mclk        ( aud_mclk    ),
        .sample_bit  ( sample_bit  ),
        .shift_bit   ( shift_bit   ),
        .bit_index   ( bit_index   ),
        .frame_start ( frame_start )
    );

    i2s_mic_receiver mic_i
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sd         ( mic_sd     ),
        .sample_bit ( sample_bit ),
        .bit_index  ( bit_index  ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  )
    );

    audio_level_path level_i
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .key        ( key        ),
        .sw         ( sw         ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  ),
        .sound      ( sound      ),
        .led        ( led        )
    );

    i2s_dac_transmitter dac_i
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .sound       ( sound       ),
        .frame_start ( frame_start ),
        .shift_bit   ( shift_bit   ),
        .bit_index   ( bit_index   ),
        .sdata       ( aud_sdata   )
    );

endmodule

// ==== design/audio_level_path.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module audio_level_path
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             key,           // Active low
    input  board_pkg::vol_t        sw,
    input  board_pkg::mic_sample_t mic_sample,
    input  logic                   mic_valid,
    output board_pkg::dac_sample_t sound,
    output board_pkg::bar_t        led
);

    localparam int NL = `N_LED;

    logic [1:0]             key_meta;
    logic [1:0]             key_sync;
    logic                   mute;         // key[0] held
    logic                   freeze;       // key[1] held
    board_pkg::dac_sample_t scaled;
    logic signed [7:0]      top8;         // Upper byte for the meter
    logic [6:0]             mag;
    logic [6:0]             mag_q;
    logic                   bar_upd;      // mic_valid one clk later
    board_pkg::bar_t        bar_next;

    assign mute   = ~key_sync[0];
    assign freeze = ~key_sync[1];

    // ------------------------------------------------------------------------
    // Volume and level math

    assign scaled = board_pkg::dac_sample_t'(mic_sample[`MIC_BITS - 1 -: `DAC_BITS]) >>> sw;
    assign top8   = mic_sample[`MIC_BITS - 1 -: 8];

    always_comb
    begin
        if (top8 == 8'sh80)
            mag = 7'd127;                 // -128 saturates
        else if (top8 < 0)
            mag = 7'(-top8);
        else
            mag = 7'(top8);
    end

    // Lowest mag/16 LEDs lit
    assign bar_next = (NL'(1) << mag_q[6:4]) - NL'(1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta <= '1;               // Released
            key_sync <= '1;
            sound    <= '0;
            bar_upd  <= 1'b0;
            led      <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
            bar_upd  <= mic_valid;
            if (mic_valid)
                sound <= mute ? '0 : scaled;
            if (bar_upd && !freeze)
                led <= bar_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mic_valid)
            mag_q <= mag;
    end

endmodule

// ==== design/i2s_dac_transmitter.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module i2s_dac_transmitter
(
    input  logic                             clk,
    input  logic                             rst,
    input  board_pkg::dac_sample_t           sound,
    input  logic                             frame_start,
    input  logic                             shift_bit,
    input  logic [$clog2(`FRAME_BITS) - 1:0] bit_index,
    output logic                             sdata
);

    localparam int IDX_W = $clog2(`FRAME_BITS);
    localparam int CH_W  = IDX_W - 1;

    board_pkg::dac_sample_t word_q;     // Word for the whole frame
    logic [`DAC_BITS - 1:0] shift_q;
    logic [CH_W - 1:0]      ch_index;   // Same for left and right halves
    logic                   load_bit;   // MSB slot of a channel
    logic                   data_bit;   // Remaining data slots

    assign ch_index = bit_index[CH_W - 1:0];
    assign load_bit = (ch_index == CH_W'(1));
    assign data_bit = (ch_index >= CH_W'(2)) && (ch_index <= CH_W'(`DAC_BITS));

    // ------------------------------------------------------------------------
    // Serial output, changes just after bclk falls

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word_q <= '0;                // First frame carries silence
            sdata  <= 1'b0;
        end
        else
        begin
            if (frame_start)
                word_q <= sound;
            if (shift_bit)
            begin
                if (load_bit)
                    sdata <= word_q[`DAC_BITS - 1];
                else if (data_bit)
                    sdata <= shift_q[`DAC_BITS - 1];
                else
                    sdata <= 1'b0;       // Idle slots
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_bit && load_bit)
            shift_q <= {word_q[`DAC_BITS - 2:0], 1'b0};   // Reload per channel
        else if (shift_bit && data_bit)
            shift_q <= {shift_q[`DAC_BITS - 2:0], 1'b0};
    end

endmodule

// ==== design/i2s_mic_receiver.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module i2s_mic_receiver
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sd,
    input  logic                             sample_bit,
    input  logic [$clog2(`FRAME_BITS) - 1:0] bit_index,
    output board_pkg::mic_sample_t           mic_sample,
    output logic                             mic_valid
);

    localparam int IDX_W = $clog2(`FRAME_BITS);

    logic [`MIC_BITS - 1:0] shift_q;    // Left word, MSB enters first
    logic                   in_word;    // Index 1 up to the LSB
    logic                   last_bit;

    // ------------------------------------------------------------------------
    // Data window in the left half

    // Index 0 is the one bit I2S delay after ws falls
    assign in_word  = (bit_index >= IDX_W'(1)) && (bit_index <= IDX_W'(`MIC_BITS));
    assign last_bit = (bit_index == IDX_W'(`MIC_BITS));

    always_ff @(posedge clk)
    begin
        if (sample_bit && in_word)
            shift_q <= {shift_q[`MIC_BITS - 2:0], sd};   // Capture on bclk rise
    end

    // ------------------------------------------------------------------------
    // Completion pulse

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mic_valid <= 1'b0;
        else
            mic_valid <= sample_bit & last_bit;   // One clk after the LSB
    end

    // Word stays put until index 1 of the next frame
    assign mic_sample = board_pkg::mic_sample_t'(shift_q);

endmodule

// ==== design/i2s_timing_ctrl.sv ====
`timescale 1ns/1ps
`include "board_consts.svh"

module i2s_timing_ctrl
(
    input  logic                             clk,
    input  logic                             rst,
    output logic                             bclk,
    output logic                             ws,
    output logic                             mclk,
    output logic                             sample_bit,
    output logic                             shift_bit,
    output logic [$clog2(`FRAME_BITS) - 1:0] bit_index,
    output logic                             frame_start
);

    localparam int DIV_W = (`BCLK_HALF > 1) ? $clog2(`BCLK_HALF) : 1;
    localparam int IDX_W = $clog2(`FRAME_BITS);

    logic [DIV_W - 1:0] div_cnt;     // Position inside a bclk half period
    logic               half_end;    // Last clk of the half period
    logic               bclk_fall;   // bclk goes low on the next edge
    logic [IDX_W - 1:0] next_index;

    // ------------------------------------------------------------------------
    // Strobes decoded from the divider

    assign half_end   = (div_cnt == DIV_W'(`BCLK_HALF - 1));
    assign bclk_fall  = half_end & bclk;
    assign sample_bit = half_end & ~bclk;    // Edge that raises bclk

    assign next_index = (bit_index == IDX_W'(`FRAME_BITS - 1)) ? '0
                                                               : bit_index + IDX_W'(1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (half_end)
            div_cnt <= '0;                   // Wrap at the half period
        else
            div_cnt <= div_cnt + DIV_W'(1);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bclk <= 1'b0;
            mclk <= 1'b0;
        end
        else
        begin
            mclk <= ~mclk;                   // clk/2
            if (half_end)
                bclk <= ~bclk;
        end
    end

    // ------------------------------------------------------------------------
    // Frame position, advanced on every bclk fall

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_index   <= '0;
            ws          <= 1'b0;
            shift_bit   <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            shift_bit   <= bclk_fall;
            frame_start <= bclk_fall & (next_index == '0);   // ws falls here
            if (bclk_fall)
            begin
                bit_index <= next_index;
                ws        <= (next_index >= IDX_W'(`FRAME_BITS / 2));  // Right half
            end
        end
    end

endmodule

// ==== design/board_pkg.sv ====
`include "board_consts.svh"

package board_pkg;

    // Raw left channel word from the microphone
    typedef logic signed [`MIC_BITS - 1:0] mic_sample_t;

    // Word sent to the DAC on both channels
    typedef logic signed [`DAC_BITS - 1:0] dac_sample_t;

    // Thermometer code, bit 0 lights first
    typedef logic        [`N_LED    - 1:0] bar_t;

    // Arithmetic right shift amount
    typedef logic        [`N_VOL    - 1:0] vol_t;

endpackage

// ==== design/board_consts.svh ====
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// ------------------------------------------------------------------------
// Serial clocking

`define BCLK_HALF   2       // clk cycles per half bclk period
`define FRAME_BITS  64      // bclk periods per frame

// ------------------------------------------------------------------------
// Word widths

`define MIC_BITS    24      // INMP441 word
`define DAC_BITS    16      // DAC word

// ------------------------------------------------------------------------
// Board controls

`define N_LED       8       // Bargraph LEDs
`define N_VOL       3       // Volume field on the switches

`endif
